//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_mips_top -f mips_pipe.f --Mdir obj_dir

# the log decides pass or fail, a missing pass line fails the target
run: compile
	./obj_dir/Vtb_mips_top | tee run.log
	grep -q "STATUS: PASS" run.log

clean:
	rm -rf obj_dir run.log

//--- dv/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

localparam logic [5:0] fn_list [5] = '{`MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_AND,
	`MIPS_FN_OR, `MIPS_FN_SLT};

logic [31:0] prog [$];    // program under test, word 0 at pc 0
logic [31:0] ref_rf [32];
logic [31:0] ref_mem [32];

function automatic logic [31:0] rtype_word(input logic [5:0] fn, input int rd, input int rs,
	input int rt);
	return {`MIPS_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

// asm order: op rt, rs, imm
function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt, input int rs,
	input int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] jump_word(input int target);
	return {`MIPS_OP_J, 26'(target)}; // word index, upper pc bits are zero
endfunction

//////////////////////////////////////////////////
// plain ISA execution, no pipeline timing
function automatic void run_reference();
	int          pc;
	int          steps;
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] addr;
	pc    = 0;
	steps = 0;
	while (prog[pc] != `MIPS_HALT_WORD && steps < 4096) begin
		w    = prog[pc];
		a    = ref_rf[w[25:21]];
		b    = ref_rf[w[20:16]];
		imm  = {{16{w[15]}}, w[15:0]};
		addr = a + imm;
		pc++;
		case (w[31:26])
			`MIPS_OP_RTYPE: begin
				case (w[5:0])
					`MIPS_FN_ADDU: ref_rf[w[15:11]] = a + b;
					`MIPS_FN_SUBU: ref_rf[w[15:11]] = a - b;
					`MIPS_FN_AND:  ref_rf[w[15:11]] = a & b;
					`MIPS_FN_OR:   ref_rf[w[15:11]] = a | b;
					`MIPS_FN_SLT:  ref_rf[w[15:11]] = {31'b0, $signed(a) < $signed(b)};
					default:       ;
				endcase
			end
			`MIPS_OP_ADDI: ref_rf[w[20:16]] = addr;
			`MIPS_OP_LW:   ref_rf[w[20:16]] = ref_mem[addr[6:2]];
			`MIPS_OP_SW:   ref_mem[addr[6:2]] = b;
			`MIPS_OP_BEQ: begin
				if (a == b) begin
					pc += int'($signed(imm));
				end
			end
			`MIPS_OP_J:    pc = int'(w[25:0]);
			default:       ;
		endcase
		ref_rf[0] = '0; // $0 is hardwired
		steps++;
	end
endfunction

// forward branches only, so every program reaches the halt word
function automatic void random_program(input int n);
	int i;
	int rd;
	int rs;
	int rt;
	prog.delete();
	for (i = 0; i < n; i++) begin
		rd = 1 + int'($urandom % 7);
		rs = int'($urandom % 8);
		rt = int'($urandom % 8);
		case ($urandom % 10)
			0, 1, 2, 3: prog.push_back(rtype_word(fn_list[$urandom % 5], rd, rs, rt));
			4, 5:       prog.push_back(itype_word(`MIPS_OP_ADDI, rd, rs, int'($urandom % 200) - 100));
			6:          prog.push_back(itype_word(`MIPS_OP_LW, rd, 0, 4 * int'($urandom % 32)));
			7:          prog.push_back(itype_word(`MIPS_OP_SW, rt, 0, 4 * int'($urandom % 32)));
			default:    prog.push_back(itype_word(`MIPS_OP_BEQ, rt, rs, int'($urandom % (n - i))));
		endcase
	end
	prog.push_back(`MIPS_HALT_WORD);
endfunction

`endif

//--- dv/tb_mips_top.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module tb_mips_top;

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     debug_flag;
	logic                     imem_we;
	logic [`MIPS_IMEM_AW-1:0] imem_addr;
	logic [`MIPS_DATA_W-1:0]  imem_wdata;
	logic [`MIPS_REG_AW-1:0]  dbg_reg_addr;
	logic [`MIPS_DMEM_AW-1:0] dbg_mem_addr;
	logic [`MIPS_DATA_W-1:0]  dbg_reg_data;
	logic [`MIPS_DATA_W-1:0]  dbg_mem_data;
	logic                     halt;
	int                       cycles = 0;
	int                       cycle_limit = 200; // grows by 6 per loaded word

	`include "mips_ref_model.svh"

	mips_top u_dut (.*);

	initial begin
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: halt not reached within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$fatal(1, "simulation timeout");
		end
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// program load, run to halt, compare
	task automatic load_program();
		int i;
		debug_flag = 1'b1;
		imem_we    = 1'b1;
		for (i = 0; i < prog.size(); i++) begin
			imem_addr  = 7'(i);
			imem_wdata = prog[i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		repeat (2) @(negedge clk); // old halt drains from the pipe
		check_eq({31'b0, halt}, 32'd0, "halt cleared by program load");
		cycle_limit += 6 * prog.size();
		debug_flag = 1'b0;
	endtask

	task automatic run_and_compare(input string name);
		int r;
		run_reference();
		load_program();
		while (halt !== 1'b1) begin
			@(negedge clk);
		end
		for (r = 0; r < 32; r++) begin
			dbg_reg_addr = 5'(r);
			dbg_mem_addr = 5'(r);
			@(negedge clk);
			check_eq(dbg_reg_data, ref_rf[r], $sformatf("%s reg %0d", name, r));
			check_eq(dbg_mem_data, ref_mem[r], $sformatf("%s mem word %0d", name, r));
			check_eq({31'b0, halt}, 32'd1, $sformatf("%s halt held", name));
		end
	endtask

	// zeroes every register and memory word so the model can start from zero
	function automatic void clear_program();
		int k;
		prog.delete();
		for (k = 1; k < 32; k++) begin
			prog.push_back(itype_word(`MIPS_OP_ADDI, k, 0, 0));
		end
		for (k = 0; k < 32; k++) begin
			prog.push_back(itype_word(`MIPS_OP_SW, 0, 0, 4 * k));
		end
		prog.push_back(`MIPS_HALT_WORD);
	endfunction

	function automatic void alu_chain_program();
		prog.delete();
		prog.push_back(itype_word(`MIPS_OP_ADDI, 1, 0, 5));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 2, 1, -3));     // mem stage fwd
		prog.push_back(rtype_word(`MIPS_FN_ADDU, 3, 1, 2));      // mem and wb fwd
		prog.push_back(rtype_word(`MIPS_FN_SUBU, 4, 3, 1));
		prog.push_back(rtype_word(`MIPS_FN_AND, 5, 4, 3));
		prog.push_back(rtype_word(`MIPS_FN_OR, 6, 5, 1));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 9, 0, -7));
		prog.push_back(rtype_word(`MIPS_FN_SLT, 7, 9, 1));       // signed compare of -7 with 5
		prog.push_back(rtype_word(`MIPS_FN_SLT, 8, 1, 9));
		prog.push_back(rtype_word(`MIPS_FN_SUBU, 10, 9, 6));
		prog.push_back(`MIPS_HALT_WORD);
	endfunction

	function automatic void load_store_program();
		prog.delete();
		prog.push_back(itype_word(`MIPS_OP_ADDI, 1, 0, 16'h1234));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 2, 0, 22));
		prog.push_back(itype_word(`MIPS_OP_SW, 1, 0, 8));
		prog.push_back(itype_word(`MIPS_OP_SW, 2, 0, 16));
		prog.push_back(itype_word(`MIPS_OP_LW, 3, 0, 8));        // same address
		prog.push_back(rtype_word(`MIPS_FN_ADDU, 4, 3, 3));      // load-use stall
		prog.push_back(itype_word(`MIPS_OP_LW, 5, 0, 16));       // other address
		prog.push_back(itype_word(`MIPS_OP_SW, 5, 0, 20));       // store of a loaded value
		prog.push_back(itype_word(`MIPS_OP_LW, 6, 0, 20));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 7, 6, 1));
		prog.push_back(`MIPS_HALT_WORD);
	endfunction

	function automatic void branch_program();
		prog.delete();
		prog.push_back(itype_word(`MIPS_OP_ADDI, 1, 0, 4));      // loop counter
		prog.push_back(itype_word(`MIPS_OP_ADDI, 2, 0, 0));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 2, 2, 3));      // loop body at 2
		prog.push_back(itype_word(`MIPS_OP_ADDI, 1, 1, -1));
		prog.push_back(itype_word(`MIPS_OP_BEQ, 0, 1, 1));       // exit to 6
		prog.push_back(jump_word(2));
		prog.push_back(itype_word(`MIPS_OP_BEQ, 0, 0, 2));       // always taken
		prog.push_back(itype_word(`MIPS_OP_ADDI, 3, 0, 99));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 4, 0, 99));
		prog.push_back(itype_word(`MIPS_OP_BEQ, 2, 1, 1));       // not taken
		prog.push_back(itype_word(`MIPS_OP_ADDI, 5, 0, 7));
		prog.push_back(jump_word(13));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 6, 0, 99));
		prog.push_back(`MIPS_HALT_WORD);
	endfunction

	function automatic void zero_reg_program();
		prog.delete();
		prog.push_back(itype_word(`MIPS_OP_ADDI, 1, 0, 9));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 0, 0, 55));
		prog.push_back(itype_word(`MIPS_OP_ADDI, 8, 0, 1));      // $0 right after a write to it
		prog.push_back(rtype_word(`MIPS_FN_ADDU, 0, 1, 1));
		prog.push_back(rtype_word(`MIPS_FN_OR, 11, 0, 1));
		prog.push_back(itype_word(`MIPS_OP_LW, 0, 0, 8));
		prog.push_back(rtype_word(`MIPS_FN_ADDU, 12, 0, 0));
		prog.push_back(`MIPS_HALT_WORD);
	endfunction

	//////////////////////////////////////////////////
	// test sequence
	initial begin
		int t;
		void'($urandom(32'haff4a818));
		rst          = 1'b1;
		debug_flag   = 1'b0;
		imem_we      = 1'b0;
		imem_addr    = '0;
		imem_wdata   = '0;
		dbg_reg_addr = '0;
		dbg_mem_addr = '0;
		for (t = 0; t < 32; t++) begin
			ref_rf[t]  = '0;
			ref_mem[t] = '0;
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;

		clear_program();
		run_and_compare("clear");
		alu_chain_program();
		run_and_compare("alu chain");
		load_store_program();
		run_and_compare("load store");
		branch_program();
		run_and_compare("branches");
		zero_reg_program();
		run_and_compare("register 0");
		for (t = 0; t < 20; t++) begin
			random_program(30);
			run_and_compare($sformatf("random %0d", t));
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- mips_pipe.f
+incdir+src
+incdir+dv
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_top.sv
dv/tb_mips_top.sv

//--- src/decode_stage.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module decode_stage import mips_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MIPS_DATA_W-1:0] if_instr,
	input  logic [`MIPS_DATA_W-1:0] if_pc4,
	input  logic                    branch_taken,
	input  logic                    wb_we,
	input  logic [`MIPS_REG_AW-1:0] wb_dest,
	input  logic [`MIPS_DATA_W-1:0] wb_data,
	input  logic [`MIPS_REG_AW-1:0] dbg_reg_addr,
	output logic                    stall,
	output logic                    halted,
	output logic                    jump,
	output logic [`MIPS_DATA_W-1:0] jump_target,
	output logic [`MIPS_DATA_W-1:0] dbg_reg_data,
	output logic [`MIPS_DATA_W-1:0] id_pc4,
	output logic [`MIPS_DATA_W-1:0] id_rs_data,
	output logic [`MIPS_DATA_W-1:0] id_rt_data,
	output logic [`MIPS_DATA_W-1:0] id_imm,
	output logic [`MIPS_REG_AW-1:0] id_rs,
	output logic [`MIPS_REG_AW-1:0] id_rt,
	output logic [`MIPS_REG_AW-1:0] id_dest,
	output ex_ctrl_t                id_ex_ctrl,
	output mem_ctrl_t               id_mem_ctrl
);

	logic [`MIPS_DATA_W-1:0] rf [0:(1<<`MIPS_REG_AW)-1];
	logic [5:0]              opcode;
	logic [5:0]              funct;
	logic [`MIPS_REG_AW-1:0] rs;
	logic [`MIPS_REG_AW-1:0] rt;
	logic [`MIPS_REG_AW-1:0] dest;
	logic [`MIPS_DATA_W-1:0] imm;
	logic [`MIPS_DATA_W-1:0] rs_data;
	logic [`MIPS_DATA_W-1:0] rt_data;
	ex_ctrl_t                ex_ctrl;
	mem_ctrl_t               mem_ctrl;

	// $0 reads zero and a write landing this edge is seen at once
	function automatic logic [`MIPS_DATA_W-1:0] rf_read(input logic [`MIPS_REG_AW-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (wb_we && wb_dest == addr) begin
			return wb_data;
		end
		return rf[addr];
	endfunction

	assign opcode      = if_instr[31:26];
	assign funct       = if_instr[5:0];
	assign rs          = if_instr[25:21];
	assign rt          = if_instr[20:16];
	assign imm         = {{16{if_instr[15]}}, if_instr[15:0]}; // sign extend
	assign jump_target = {if_pc4[31:28], if_instr[25:0], 2'b00};
	assign jump        = (opcode == `MIPS_OP_J);
	assign halted      = (if_instr == `MIPS_HALT_WORD);
	assign stall       = id_mem_ctrl.mem_read && (id_dest == rs || id_dest == rt);

	always_comb begin
		rs_data      = rf_read(rs);
		rt_data      = rf_read(rt);
		dbg_reg_data = rf_read(dbg_reg_addr);
	end

	//////////////////////////////////////////////////
	// instruction decoder
	always_comb begin
		ex_ctrl  = '0;
		mem_ctrl = '0;
		dest     = rt; // i-type writes rt
		case (opcode)
			`MIPS_OP_RTYPE: begin
				dest               = if_instr[15:11];
				mem_ctrl.reg_write = 1'b1;
				case (funct)
					`MIPS_FN_ADDU: ex_ctrl.alu_op = alu_add;
					`MIPS_FN_SUBU: ex_ctrl.alu_op = alu_sub;
					`MIPS_FN_AND:  ex_ctrl.alu_op = alu_and;
					`MIPS_FN_OR:   ex_ctrl.alu_op = alu_or;
					`MIPS_FN_SLT:  ex_ctrl.alu_op = alu_slt;
					default:       mem_ctrl.reg_write = 1'b0; // unsupported funct is a nop
				endcase
			end
			`MIPS_OP_ADDI: begin
				ex_ctrl.alu_src_imm = 1'b1;
				mem_ctrl.reg_write  = 1'b1;
			end
			`MIPS_OP_LW: begin
				ex_ctrl.alu_src_imm = 1'b1;
				mem_ctrl.mem_read   = 1'b1;
				mem_ctrl.reg_write  = 1'b1;
				mem_ctrl.mem_to_reg = 1'b1;
			end
			`MIPS_OP_SW: begin
				ex_ctrl.alu_src_imm = 1'b1;
				mem_ctrl.mem_write  = 1'b1;
			end
			`MIPS_OP_BEQ: begin
				ex_ctrl.alu_op = alu_sub; // zero flag compares rs, rt
				ex_ctrl.branch = 1'b1;
			end
			default: mem_ctrl.halt = halted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wb_we && wb_dest != '0) begin
			rf[wb_dest] <= wb_data;
		end
	end

	//////////////////////////////////////////////////
	// id/ex register
	always_ff @(posedge clk) begin
		if (rst || branch_taken || stall) begin
			id_ex_ctrl  <= '0; // bubble
			id_mem_ctrl <= '0;
		end else begin
			id_ex_ctrl  <= ex_ctrl;
			id_mem_ctrl <= mem_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		id_pc4     <= if_pc4;
		id_rs_data <= rs_data;
		id_rt_data <= rt_data;
		id_imm     <= imm;
		id_rs      <= rs;
		id_rt      <= rt;
		id_dest    <= dest;
	end

	// the bubble behind a load ends the load-use stall after one cycle
	assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
		else $error("load-use stall held for more than one cycle");

endmodule

//--- src/execute_stage.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module execute_stage import mips_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    branch_taken,
	input  logic [`MIPS_DATA_W-1:0] id_pc4,
	input  logic [`MIPS_DATA_W-1:0] id_rs_data,
	input  logic [`MIPS_DATA_W-1:0] id_rt_data,
	input  logic [`MIPS_DATA_W-1:0] id_imm,
	input  logic [`MIPS_REG_AW-1:0] id_rs,
	input  logic [`MIPS_REG_AW-1:0] id_rt,
	input  logic [`MIPS_REG_AW-1:0] id_dest,
	input  ex_ctrl_t                id_ex_ctrl,
	input  mem_ctrl_t               id_mem_ctrl,
	input  logic [`MIPS_DATA_W-1:0] mem_fwd_data,
	input  logic [`MIPS_REG_AW-1:0] mem_fwd_dest,
	input  logic                    mem_fwd_we,
	input  logic                    wb_we,
	input  logic [`MIPS_REG_AW-1:0] wb_dest,
	input  logic [`MIPS_DATA_W-1:0] wb_data,
	output logic [`MIPS_DATA_W-1:0] ex_alu,
	output logic [`MIPS_DATA_W-1:0] ex_store_data,
	output logic [`MIPS_REG_AW-1:0] ex_dest,
	output logic                    ex_zero,
	output logic                    ex_branch,
	output logic [`MIPS_DATA_W-1:0] ex_branch_target,
	output mem_ctrl_t               ex_mem_ctrl
);

	logic [`MIPS_DATA_W-1:0] op_a;
	logic [`MIPS_DATA_W-1:0] rt_val;
	logic [`MIPS_DATA_W-1:0] op_b;
	logic [`MIPS_DATA_W-1:0] alu_y;

	// memory stage wins over writeback, the younger result
	function automatic logic [`MIPS_DATA_W-1:0] fwd(input logic [`MIPS_REG_AW-1:0] src,
		input logic [`MIPS_DATA_W-1:0] reg_val);
		if (mem_fwd_we && mem_fwd_dest != '0 && mem_fwd_dest == src) begin
			return mem_fwd_data;
		end
		if (wb_we && wb_dest != '0 && wb_dest == src) begin
			return wb_data;
		end
		return reg_val;
	endfunction

	always_comb begin
		op_a   = fwd(id_rs, id_rs_data);
		rt_val = fwd(id_rt, id_rt_data); // also the store data
		op_b   = id_ex_ctrl.alu_src_imm ? id_imm : rt_val;
	end

	always_comb begin
		case (id_ex_ctrl.alu_op)
			alu_add: alu_y = op_a + op_b;
			alu_sub: alu_y = op_a - op_b;
			alu_and: alu_y = op_a & op_b;
			alu_or:  alu_y = op_a | op_b;
			alu_slt: alu_y = `MIPS_DATA_W'($signed(op_a) < $signed(op_b));
			default: alu_y = op_a + op_b;
		endcase
	end

	//////////////////////////////////////////////////
	// ex/mem register
	always_ff @(posedge clk) begin
		if (rst || branch_taken) begin
			ex_mem_ctrl <= '0; // squash the slot behind a taken beq
			ex_branch   <= 1'b0;
		end else begin
			ex_mem_ctrl <= id_mem_ctrl;
			ex_branch   <= id_ex_ctrl.branch;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu           <= alu_y;
		ex_store_data    <= rt_val;
		ex_dest          <= id_dest;
		ex_zero          <= (alu_y == '0);
		ex_branch_target <= id_pc4 + (id_imm << 2);
	end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module fetch_stage (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     debug_flag,
	input  logic                     imem_we,
	input  logic [`MIPS_IMEM_AW-1:0] imem_addr,
	input  logic [`MIPS_DATA_W-1:0]  imem_wdata,
	input  logic                     stall,
	input  logic                     halted,
	input  logic                     jump,
	input  logic [`MIPS_DATA_W-1:0]  jump_target,
	input  logic                     branch_taken,
	input  logic [`MIPS_DATA_W-1:0]  branch_target,
	output logic [`MIPS_DATA_W-1:0]  if_instr,
	output logic [`MIPS_DATA_W-1:0]  if_pc4
);

	logic [`MIPS_DATA_W-1:0] imem [0:(1<<`MIPS_IMEM_AW)-1];
	logic [`MIPS_DATA_W-1:0] pc;
	logic [`MIPS_DATA_W-1:0] pc4;
	logic                    hold;
	logic                    flush;

	assign pc4   = pc + `MIPS_DATA_W'(4);
	assign hold  = stall | halted; // load-use or halt seen in decode
	assign flush = debug_flag | branch_taken | jump;

	always_ff @(posedge clk) begin
		if (debug_flag && imem_we) begin
			imem[imem_addr] <= imem_wdata; // program load
		end
	end

	//////////////////////////////////////////////////
	// program counter
	always_ff @(posedge clk) begin
		if (rst || debug_flag) begin
			pc <= '0; // restarts from 0 when debug_flag falls
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (jump) begin
			pc <= jump_target;
		end else if (!hold) begin
			pc <= pc4;
		end
	end

	//////////////////////////////////////////////////
	// if/id register
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			if_instr <= '0; // all-zero word decodes as a bubble
		end else if (!hold) begin
			if_instr <= imem[pc[`MIPS_IMEM_AW+1:2]];
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			if_pc4 <= pc4;
		end
	end

	// instruction memory may only change while the pipeline is held
	assert property (@(posedge clk) disable iff (rst) imem_we |-> debug_flag)
		else $error("imem_we high without debug_flag");

endmodule

//--- src/memory_stage.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module memory_stage import mips_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     debug_flag,
	input  logic [`MIPS_DATA_W-1:0]  ex_alu,
	input  logic [`MIPS_DATA_W-1:0]  ex_store_data,
	input  logic [`MIPS_REG_AW-1:0]  ex_dest,
	input  logic                     ex_zero,
	input  logic                     ex_branch,
	input  logic [`MIPS_DATA_W-1:0]  ex_branch_target,
	input  mem_ctrl_t                ex_mem_ctrl,
	input  logic [`MIPS_DMEM_AW-1:0] dbg_mem_addr,
	output logic                     branch_taken,
	output logic [`MIPS_DATA_W-1:0]  branch_target,
	output logic [`MIPS_DATA_W-1:0]  mem_fwd_data,
	output logic [`MIPS_REG_AW-1:0]  mem_fwd_dest,
	output logic                     mem_fwd_we,
	output logic                     wb_we,
	output logic [`MIPS_REG_AW-1:0]  wb_dest,
	output logic [`MIPS_DATA_W-1:0]  wb_data,
	output logic                     halt,
	output logic [`MIPS_DATA_W-1:0]  dbg_mem_data
);

	logic [`MIPS_DATA_W-1:0]  dmem [0:(1<<`MIPS_DMEM_AW)-1];
	logic [`MIPS_DMEM_AW-1:0] dmem_addr;
	logic [`MIPS_DATA_W-1:0]  load_data;

	assign dmem_addr     = ex_alu[`MIPS_DMEM_AW+1:2]; // word address
	assign load_data     = dmem[dmem_addr];
	assign dbg_mem_data  = dmem[dbg_mem_addr];
	assign branch_taken  = ex_branch & ex_zero;
	assign branch_target = ex_branch_target;

	// alu result held here, loads excluded as data is not back yet
	assign mem_fwd_data  = ex_alu;
	assign mem_fwd_dest  = ex_dest;
	assign mem_fwd_we    = ex_mem_ctrl.reg_write & ~ex_mem_ctrl.mem_read;

	always_ff @(posedge clk) begin
		if (ex_mem_ctrl.mem_write) begin
			dmem[dmem_addr] <= ex_store_data;
		end
	end

	//////////////////////////////////////////////////
	// mem/wb register and halt
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= ex_mem_ctrl.reg_write;
		end
	end

	always_ff @(posedge clk) begin
		wb_dest <= ex_dest;
		wb_data <= ex_mem_ctrl.mem_to_reg ? load_data : ex_alu;
	end

	always_ff @(posedge clk) begin
		if (rst || debug_flag) begin
			halt <= 1'b0; // cleared by the next program load
		end else if (ex_mem_ctrl.halt) begin
			halt <= 1'b1; // sticky
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		!(ex_mem_ctrl.mem_read && ex_mem_ctrl.mem_write))
		else $error("load and store in the same slot");

endmodule

//--- src/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath and memory sizes
`define MIPS_DATA_W    32
`define MIPS_REG_AW    5
`define MIPS_IMEM_AW   7
`define MIPS_DMEM_AW   5

// opcodes, bits 31:26
`define MIPS_OP_RTYPE  6'h00
`define MIPS_OP_ADDI   6'h08
`define MIPS_OP_LW     6'h23
`define MIPS_OP_SW     6'h2b
`define MIPS_OP_BEQ    6'h04
`define MIPS_OP_J      6'h02

// r-type funct codes, bits 5:0
`define MIPS_FN_ADDU   6'h21
`define MIPS_FN_SUBU   6'h23
`define MIPS_FN_AND    6'h24
`define MIPS_FN_OR     6'h25
`define MIPS_FN_SLT    6'h2a

`define MIPS_HALT_WORD 32'hffff_ffff

`endif

//--- src/mips_pkg.sv
package mips_pkg;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	// consumed in execute
	typedef struct packed {
		alu_op_t alu_op;
		logic    alu_src_imm; // operand b from immediate
		logic    branch;      // beq
	} ex_ctrl_t;

	// consumed in memory and writeback
	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic mem_to_reg; // load data to rf
		logic halt;
	} mem_ctrl_t;

endpackage

//--- src/mips_top.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_top import mips_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     debug_flag,
	input  logic                     imem_we,
	input  logic [`MIPS_IMEM_AW-1:0] imem_addr,
	input  logic [`MIPS_DATA_W-1:0]  imem_wdata,
	input  logic [`MIPS_REG_AW-1:0]  dbg_reg_addr,
	input  logic [`MIPS_DMEM_AW-1:0] dbg_mem_addr,
	output logic [`MIPS_DATA_W-1:0]  dbg_reg_data,
	output logic [`MIPS_DATA_W-1:0]  dbg_mem_data,
	output logic                     halt
);

	//////////////////////////////////////////////////
	// stage to stage wires, named as the stage ports
	logic [`MIPS_DATA_W-1:0] if_instr;
	logic [`MIPS_DATA_W-1:0] if_pc4;
	logic                    stall;
	logic                    halted;
	logic                    jump;
	logic [`MIPS_DATA_W-1:0] jump_target;
	logic [`MIPS_DATA_W-1:0] id_pc4;
	logic [`MIPS_DATA_W-1:0] id_rs_data;
	logic [`MIPS_DATA_W-1:0] id_rt_data;
	logic [`MIPS_DATA_W-1:0] id_imm;
	logic [`MIPS_REG_AW-1:0] id_rs;
	logic [`MIPS_REG_AW-1:0] id_rt;
	logic [`MIPS_REG_AW-1:0] id_dest;
	ex_ctrl_t                id_ex_ctrl;
	mem_ctrl_t               id_mem_ctrl;
	logic [`MIPS_DATA_W-1:0] ex_alu;
	logic [`MIPS_DATA_W-1:0] ex_store_data;
	logic [`MIPS_REG_AW-1:0] ex_dest;
	logic                    ex_zero;
	logic                    ex_branch;
	logic [`MIPS_DATA_W-1:0] ex_branch_target;
	mem_ctrl_t               ex_mem_ctrl;
	logic                    branch_taken;
	logic [`MIPS_DATA_W-1:0] branch_target;
	logic [`MIPS_DATA_W-1:0] mem_fwd_data;
	logic [`MIPS_REG_AW-1:0] mem_fwd_dest;
	logic                    mem_fwd_we;
	logic                    wb_we;
	logic [`MIPS_REG_AW-1:0] wb_dest;
	logic [`MIPS_DATA_W-1:0] wb_data;

	fetch_stage   u_fetch   (.*); // pc, imem, if/id
	decode_stage  u_decode  (.*); // decoder, rf, id/ex
	execute_stage u_execute (.*); // forwarding, alu, ex/mem
	memory_stage  u_memory  (.*); // dmem, branch, mem/wb, halt

endmodule
